// File: verilog/panel_pkg.sv
/* Panel controller package.
   Panel geometry, pixel and address types, opcodes and engine states. */
`default_nettype none

package panel_pkg;

    localparam int PANEL_WIDTH = 16;
    localparam int PANEL_HEIGHT = 8;
    localparam int BYTES_PER_PIXEL = 3;
    localparam int FB_DEPTH = PANEL_WIDTH * PANEL_HEIGHT;
    localparam int NUM_MASTERS = 3;
    localparam int SET_PIXEL_BYTES = 2 + BYTES_PER_PIXEL;  // Row, column, colour.

    localparam logic [7:0] OP_FILL_PANEL = 8'h01;
    localparam logic [7:0] OP_SET_PIXEL = 8'h02;

    typedef logic [BYTES_PER_PIXEL*8-1:0] pixel_t;  // First byte received is the MSB.
    typedef logic [$clog2(FB_DEPTH)-1:0] fb_addr_t;
    typedef logic [$clog2(NUM_MASTERS)-1:0] master_id_t;

    typedef enum logic [2:0] {
        ST_CAPTURE,
        ST_START,
        ST_RUNNING,
        ST_PREDONE,
        ST_DONE
    } engine_state_t;

endpackage

`default_nettype wire

// File: verilog/fb_bus_if.sv
/* Wishbone classic link to the framebuffer. */
`timescale 1ns/1ps
`default_nettype none

interface fb_bus_if import panel_pkg::*; ();

    logic cyc;
    logic stb;
    logic we;
    fb_addr_t adr;
    pixel_t dat_w;
    pixel_t dat_r;
    logic ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input dat_r, ack
    );

    modport slave (
        input cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// File: verilog/cmd_stream_if.sv
/* Byte hand-off between the command dispatcher and a drawing engine. */
`timescale 1ns/1ps
`default_nettype none

interface cmd_stream_if;

    logic valid;
    logic [7:0] data;
    logic ready;
    logic done;  // One-cycle pulse after the last write.

    modport source (output valid, data, input ready, done);

    modport sink (input valid, data, output ready, done);

endinterface

`default_nettype wire

// File: verilog/fb_arbiter.sv
/* Round-robin arbiter for three Wishbone masters.
   The grant is registered and held while the owner keeps cyc high. */
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter import panel_pkg::*; (
    input wire clk,
    input wire reset,
    fb_bus_if.slave m0,
    fb_bus_if.slave m1,
    fb_bus_if.slave m2,
    fb_bus_if.master s
);

    logic busy;
    master_id_t owner;
    master_id_t last_owner;
    master_id_t next_owner;

    logic [NUM_MASTERS-1:0] m_cyc;
    logic [NUM_MASTERS-1:0] m_stb;
    logic [NUM_MASTERS-1:0] m_we;
    fb_addr_t m_adr [NUM_MASTERS];
    pixel_t m_dat [NUM_MASTERS];

    assign m_cyc = {m2.cyc, m1.cyc, m0.cyc};
    assign m_stb = {m2.stb, m1.stb, m0.stb};
    assign m_we = {m2.we, m1.we, m0.we};
    assign m_adr[0] = m0.adr;
    assign m_adr[1] = m1.adr;
    assign m_adr[2] = m2.adr;
    assign m_dat[0] = m0.dat_w;
    assign m_dat[1] = m1.dat_w;
    assign m_dat[2] = m2.dat_w;

    // First requester after the last owner wins.
    always_comb begin
        int cand;
        next_owner = last_owner;
        for (int i = NUM_MASTERS; i >= 1; i--) begin
            cand = (int'(last_owner) + i) % NUM_MASTERS;
            if (m_cyc[cand]) next_owner = master_id_t'(cand);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            owner <= '0;
            last_owner <= master_id_t'(NUM_MASTERS - 1);
        end else if (!busy) begin
            if (|m_cyc) begin
                busy <= 1'b1;
                owner <= next_owner;
            end
        end else if (!m_cyc[owner]) begin
            busy <= 1'b0;  // Owner let go.
            last_owner <= owner;
        end
    end

    // ************************************************************************
    // Bus mux.
    assign s.cyc = busy && m_cyc[owner];
    assign s.stb = busy && m_stb[owner];
    assign s.we = m_we[owner];
    assign s.adr = m_adr[owner];
    assign s.dat_w = m_dat[owner];

    assign m0.ack = busy && (owner == master_id_t'(0)) && s.ack;
    assign m1.ack = busy && (owner == master_id_t'(1)) && s.ack;
    assign m2.ack = busy && (owner == master_id_t'(2)) && s.ack;
    assign m0.dat_r = (owner == master_id_t'(0)) ? s.dat_r : '0;
    assign m1.dat_r = (owner == master_id_t'(1)) ? s.dat_r : '0;
    assign m2.dat_r = (owner == master_id_t'(2)) ? s.dat_r : '0;

endmodule

`default_nettype wire

// File: verilog/framebuffer_ram.sv
/* Framebuffer pixel memory behind a Wishbone classic slave port. */
`timescale 1ns/1ps
`default_nettype none

module framebuffer_ram import panel_pkg::*; (
    input wire clk,
    input wire reset,
    fb_bus_if.slave bus
);

    pixel_t mem [FB_DEPTH];
    logic access;

    assign access = bus.cyc && bus.stb && !bus.ack;  // New request with no ack pending.

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                mem[bus.adr] <= bus.dat_w;
            end else begin
                bus.dat_r <= mem[bus.adr];  // Valid together with ack.
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/cmd_dispatch.sv
/* Command dispatcher.
   Decodes the opcode byte and hands the payload to the selected engine. */
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch import panel_pkg::*; (
    input wire clk,
    input wire reset,
    input wire cmd_valid,
    input wire [7:0] cmd_data,
    output logic cmd_ready,
    output logic cmd_done,
    cmd_stream_if.source fill,
    cmd_stream_if.source setpix
);

    logic busy;
    logic sel_setpix;
    logic op_known;

    assign op_known = (cmd_data == OP_FILL_PANEL) || (cmd_data == OP_SET_PIXEL);

    assign fill.data = cmd_data;
    assign setpix.data = cmd_data;
    assign fill.valid = cmd_valid && busy && !sel_setpix;
    assign setpix.valid = cmd_valid && busy && sel_setpix;

    // Idle always takes the opcode byte.
    assign cmd_ready = busy ? (sel_setpix ? setpix.ready : fill.ready) : 1'b1;
    assign cmd_done = busy && (sel_setpix ? setpix.done : fill.done);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            sel_setpix <= 1'b0;
        end else if (!busy) begin
            if (cmd_valid && op_known) begin  // Unknown opcodes fall through.
                busy <= 1'b1;
                sel_setpix <= (cmd_data == OP_SET_PIXEL);
            end
        end else if (cmd_done) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cmd_fill_panel.sv
/* Fill panel engine.
   Captures one colour and writes it to every framebuffer address. */
`timescale 1ns/1ps
`default_nettype none

module cmd_fill_panel import panel_pkg::*; (
    input wire clk,
    input wire reset,
    cmd_stream_if.sink cmd,
    fb_bus_if.master bus
);

    engine_state_t state;
    pixel_t colour;
    logic [1:0] bytes_left;
    fb_addr_t addr;
    logic last_addr;

    assign last_addr = (addr == fb_addr_t'(FB_DEPTH - 1));

    assign bus.we = 1'b1;
    assign bus.stb = bus.cyc;
    assign bus.adr = addr;
    assign bus.dat_w = colour;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            bytes_left <= 2'(BYTES_PER_PIXEL - 1);
            cmd.ready <= 1'b1;
            cmd.done <= 1'b0;
            bus.cyc <= 1'b0;
            addr <= '0;
        end else begin
            case (state)
                ST_CAPTURE: begin
                    if (cmd.valid && cmd.ready) begin
                        colour <= {colour[$bits(pixel_t)-9:0], cmd.data};
                        if (bytes_left == 2'd0) begin
                            state <= ST_START;
                            cmd.ready <= 1'b0;
                        end else begin
                            bytes_left <= bytes_left - 2'd1;
                        end
                    end
                end
                ST_START: begin
                    addr <= '0;
                    bus.cyc <= 1'b1;
                    state <= ST_RUNNING;
                end
                // ************************************************************
                // Area walk, one classic cycle per pixel.
                ST_RUNNING: begin
                    if (bus.cyc && bus.ack) begin
                        bus.cyc <= 1'b0;
                        if (last_addr) begin
                            state <= ST_PREDONE;
                        end else begin
                            addr <= addr + fb_addr_t'(1);  // Walk moves only on ack.
                        end
                    end else if (!bus.cyc) begin
                        bus.cyc <= 1'b1;
                    end
                end
                ST_PREDONE: begin
                    addr <= '0;
                    cmd.done <= 1'b1;
                    state <= ST_DONE;
                end
                ST_DONE: begin
                    cmd.done <= 1'b0;
                    cmd.ready <= 1'b1;
                    bytes_left <= 2'(BYTES_PER_PIXEL - 1);
                    state <= ST_CAPTURE;
                end
                default: state <= ST_CAPTURE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/cmd_set_pixel.sv
/* Set pixel engine.
   Captures row, column and colour, then writes one pixel if it is on the panel. */
`timescale 1ns/1ps
`default_nettype none

module cmd_set_pixel import panel_pkg::*; (
    input wire clk,
    input wire reset,
    cmd_stream_if.sink cmd,
    fb_bus_if.master bus
);

    engine_state_t state;
    logic [2:0] bytes_left;
    logic [7:0] row;
    logic [7:0] col;
    pixel_t colour;
    logic in_range;

    assign in_range = (int'(row) < PANEL_HEIGHT) && (int'(col) < PANEL_WIDTH);

    assign bus.we = 1'b1;
    assign bus.stb = bus.cyc;
    assign bus.adr = fb_addr_t'(int'(row) * PANEL_WIDTH + int'(col));
    assign bus.dat_w = colour;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            bytes_left <= 3'(SET_PIXEL_BYTES - 1);
            cmd.ready <= 1'b1;
            cmd.done <= 1'b0;
            bus.cyc <= 1'b0;
        end else begin
            case (state)
                ST_CAPTURE: begin
                    if (cmd.valid && cmd.ready) begin
                        if (bytes_left == 3'(SET_PIXEL_BYTES - 1)) begin
                            row <= cmd.data;
                        end else if (bytes_left == 3'(SET_PIXEL_BYTES - 2)) begin
                            col <= cmd.data;
                        end else begin
                            colour <= {colour[$bits(pixel_t)-9:0], cmd.data};
                        end
                        if (bytes_left == 3'd0) begin
                            state <= ST_START;
                            cmd.ready <= 1'b0;
                        end else begin
                            bytes_left <= bytes_left - 3'd1;
                        end
                    end
                end
                ST_START: begin
                    if (in_range) begin
                        bus.cyc <= 1'b1;
                        state <= ST_RUNNING;
                    end else begin
                        cmd.done <= 1'b1;  // No write off the panel.
                        state <= ST_DONE;
                    end
                end
                ST_RUNNING: begin
                    if (bus.ack) begin
                        bus.cyc <= 1'b0;
                        state <= ST_PREDONE;
                    end
                end
                ST_PREDONE: begin
                    cmd.done <= 1'b1;
                    state <= ST_DONE;
                end
                ST_DONE: begin
                    cmd.done <= 1'b0;
                    cmd.ready <= 1'b1;
                    bytes_left <= 3'(SET_PIXEL_BYTES - 1);
                    state <= ST_CAPTURE;
                end
                default: state <= ST_CAPTURE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/pixel_reader.sv
/* Pixel reader.
   Turns a host read request into one Wishbone read cycle. */
`timescale 1ns/1ps
`default_nettype none

module pixel_reader import panel_pkg::*; (
    input wire clk,
    input wire reset,
    input wire rd_req,
    input wire [7:0] rd_row,
    input wire [7:0] rd_col,
    output logic rd_busy,
    output logic rd_ack,
    output pixel_t rd_data,
    fb_bus_if.master bus
);

    fb_addr_t addr;

    assign bus.we = 1'b0;
    assign bus.stb = bus.cyc;
    assign bus.adr = addr;
    assign bus.dat_w = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_busy <= 1'b0;
            rd_ack <= 1'b0;
            bus.cyc <= 1'b0;
        end else begin
            rd_ack <= 1'b0;
            if (!rd_busy) begin
                if (rd_req) begin
                    // Positions off the panel wrap inside the framebuffer.
                    addr <= fb_addr_t'(int'(rd_row) * PANEL_WIDTH + int'(rd_col));
                    rd_busy <= 1'b1;
                    bus.cyc <= 1'b1;
                end
            end else if (bus.ack) begin
                bus.cyc <= 1'b0;
                rd_busy <= 1'b0;
                rd_ack <= 1'b1;
                rd_data <= bus.dat_r;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/panel_ctrl_top.sv
/* LED panel command controller.
   Dispatcher, drawing engines and pixel reader sharing one framebuffer. */
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_top import panel_pkg::*; (
    input wire clk,
    input wire reset,
    input wire cmd_valid,
    input wire [7:0] cmd_data,
    output logic cmd_ready,
    output logic cmd_done,
    input wire rd_req,
    input wire [7:0] rd_row,
    input wire [7:0] rd_col,
    output logic rd_busy,
    output logic rd_ack,
    output pixel_t rd_data
);

    cmd_stream_if fill_cmd ();
    cmd_stream_if setpix_cmd ();

    fb_bus_if fill_bus ();    // Master 0.
    fb_bus_if setpix_bus ();  // Master 1.
    fb_bus_if rd_bus ();      // Master 2.
    fb_bus_if ram_bus ();

    // ************************************************************************
    // Command path.
    cmd_dispatch i_cmd_dispatch (
        .clk(clk),
        .reset(reset),
        .cmd_valid(cmd_valid),
        .cmd_data(cmd_data),
        .cmd_ready(cmd_ready),
        .cmd_done(cmd_done),
        .fill(fill_cmd),
        .setpix(setpix_cmd)
    );

    cmd_fill_panel i_cmd_fill_panel (
        .clk(clk),
        .reset(reset),
        .cmd(fill_cmd),
        .bus(fill_bus)
    );

    cmd_set_pixel i_cmd_set_pixel (
        .clk(clk),
        .reset(reset),
        .cmd(setpix_cmd),
        .bus(setpix_bus)
    );

    pixel_reader i_pixel_reader (
        .clk(clk),
        .reset(reset),
        .rd_req(rd_req),
        .rd_row(rd_row),
        .rd_col(rd_col),
        .rd_busy(rd_busy),
        .rd_ack(rd_ack),
        .rd_data(rd_data),
        .bus(rd_bus)
    );

    // ************************************************************************
    // Framebuffer side.
    fb_arbiter i_fb_arbiter (
        .clk(clk),
        .reset(reset),
        .m0(fill_bus),
        .m1(setpix_bus),
        .m2(rd_bus),
        .s(ram_bus)
    );

    framebuffer_ram i_framebuffer_ram (
        .clk(clk),
        .reset(reset),
        .bus(ram_bus)
    );

endmodule

`default_nettype wire

// File: bench/panel_ctrl_tb.sv
/* Panel controller testbench.
   Table-driven commands and reads checked against a model framebuffer. */
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_tb import panel_pkg::*; ();

    localparam logic [2:0] K_CMD = 3'd0;      // Command bytes that end in one cmd_done.
    localparam logic [2:0] K_BAD = 3'd1;      // Unknown opcode that gives no cmd_done.
    localparam logic [2:0] K_READ = 3'd2;
    localparam logic [2:0] K_SWEEP = 3'd3;    // Read every pixel against the model.
    localparam logic [2:0] K_CONTEND = 3'd4;  // Fill with random reads alongside.
    localparam int NUM_ENTRIES = 17;
    localparam int WATCH_CYCLES = 8;
    // Table length times about 4 cycles per pixel, plus margin.
    localparam int TIMEOUT_CYCLES = 20000;

    typedef struct packed {
        logic [2:0] kind;
        logic [2:0] nbytes;
        logic [0:5][7:0] bytes;
        logic [7:0] row;
        logic [7:0] col;
        pixel_t exp_px;
    } entry_t;

    localparam entry_t TESTS [NUM_ENTRIES] = '{
        '{K_CMD, 3'd4, {OP_FILL_PANEL, 24'h112233, 16'h0}, 8'd0, 8'd0, 24'h0},
        '{K_READ, 3'd0, 48'h0, 8'd0, 8'd0, 24'h112233},
        '{K_READ, 3'd0, 48'h0, 8'd7, 8'd15, 24'h112233},
        '{K_CMD, 3'd6, {OP_SET_PIXEL, 8'd3, 8'd9, 24'ha1b2c3}, 8'd0, 8'd0, 24'h0},
        '{K_READ, 3'd0, 48'h0, 8'd3, 8'd9, 24'ha1b2c3},
        '{K_READ, 3'd0, 48'h0, 8'd3, 8'd8, 24'h112233},
        '{K_READ, 3'd0, 48'h0, 8'd3, 8'd10, 24'h112233},
        '{K_READ, 3'd0, 48'h0, 8'd2, 8'd9, 24'h112233},
        '{K_READ, 3'd0, 48'h0, 8'd4, 8'd9, 24'h112233},
        '{K_CMD, 3'd6, {OP_SET_PIXEL, 8'd8, 8'd0, 24'hffffff}, 8'd0, 8'd0, 24'h0},
        '{K_CMD, 3'd6, {OP_SET_PIXEL, 8'd0, 8'd16, 24'heeeeee}, 8'd0, 8'd0, 24'h0},
        '{K_SWEEP, 3'd0, 48'h0, 8'd0, 8'd0, 24'h0},
        '{K_BAD, 3'd1, {8'h7f, 40'h0}, 8'd0, 8'd0, 24'h0},
        '{K_CMD, 3'd6, {OP_SET_PIXEL, 8'd0, 8'd0, 24'h445566}, 8'd0, 8'd0, 24'h0},
        '{K_READ, 3'd0, 48'h0, 8'd0, 8'd0, 24'h445566},
        '{K_CONTEND, 3'd4, {OP_FILL_PANEL, 24'h0a0b0c, 16'h0}, 8'd0, 8'd0, 24'h0},
        '{K_SWEEP, 3'd0, 48'h0, 8'd0, 8'd0, 24'h0}
    };

    logic clk;
    logic reset;
    logic cmd_valid;
    logic [7:0] cmd_data;
    logic cmd_ready;
    logic cmd_done;
    logic rd_req;
    logic [7:0] rd_row;
    logic [7:0] rd_col;
    logic rd_busy;
    logic rd_ack;
    pixel_t rd_data;

    pixel_t model [FB_DEPTH];
    integer seed;
    int cycles;
    int test_errs;
    int total_errs;
    int failed;

    panel_ctrl_top i_panel_ctrl_top (
        .clk(clk),
        .reset(reset),
        .cmd_valid(cmd_valid),
        .cmd_data(cmd_data),
        .cmd_ready(cmd_ready),
        .cmd_done(cmd_done),
        .rd_req(rd_req),
        .rd_row(rd_row),
        .rd_col(rd_col),
        .rd_busy(rd_busy),
        .rd_ack(rd_ack),
        .rd_data(rd_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // ************************************************************************
    // Bus-level tasks. Each starts and ends 1 ns after a rising edge.
    task automatic send_byte(input logic [7:0] b);
        cmd_valid = 1'b1;
        cmd_data = b;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic read_pixel(input logic [7:0] row, input logic [7:0] col,
                              output pixel_t data);
        rd_req = 1'b1;
        rd_row = row;
        rd_col = col;
        @(negedge clk);
        while (rd_busy) @(negedge clk);
        @(posedge clk);
        #1;
        rd_req = 1'b0;
        @(negedge clk);
        while (!rd_ack) @(negedge clk);
        data = rd_data;
        @(posedge clk);
        #1;
    endtask

    // Counts cmd_done pulses over a fixed window.
    task automatic watch_done(input int n, output int pulses);
        pulses = 0;
        repeat (n) begin
            @(negedge clk);
            if (cmd_done) pulses++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_done(output int pulses);
        int extra;
        @(negedge clk);
        while (!cmd_done) @(negedge clk);
        @(posedge clk);
        #1;
        watch_done(WATCH_CYCLES, extra);
        pulses = 1 + extra;
    endtask

    // ************************************************************************
    // Reference model.
    task automatic update_model(input entry_t e);
        int r;
        int c;
        r = int'(e.bytes[1]);
        c = int'(e.bytes[2]);
        if (e.bytes[0] == OP_FILL_PANEL) begin
            for (int a = 0; a < FB_DEPTH; a++) model[a] = {e.bytes[1], e.bytes[2], e.bytes[3]};
        end else if (e.bytes[0] == OP_SET_PIXEL) begin
            if (r < PANEL_HEIGHT && c < PANEL_WIDTH) begin  // Off-panel writes are dropped.
                model[r * PANEL_WIDTH + c] = {e.bytes[3], e.bytes[4], e.bytes[5]};
            end
        end
    endtask

    task automatic compare_read(input logic [7:0] row, input logic [7:0] col,
                                input pixel_t exp_px);
        pixel_t got;
        read_pixel(row, col, got);
        if (got !== exp_px) begin
            $display("mismatch rd_data at (%0d,%0d): got %h, expected %h", row, col, got, exp_px);
            test_errs++;
        end
    endtask

    // Fill with random-address reads issued every cycle the reader is free.
    task automatic fill_under_reads(input entry_t e);
        int sent;
        int pulses;
        int extra;
        bit pending;
        int raddr;
        logic [31:0] r;
        pixel_t new_px;
        new_px = {e.bytes[1], e.bytes[2], e.bytes[3]};
        sent = 0;
        pulses = 0;
        pending = 1'b0;
        raddr = 0;
        while (pulses == 0 || pending) begin
            cmd_valid = (sent < int'(e.nbytes));
            cmd_data = (sent < int'(e.nbytes)) ? e.bytes[sent] : 8'h00;
            rd_req = !pending && pulses == 0;
            if (rd_req) begin
                r = $random(seed);
                rd_row = {5'd0, r[2:0]};
                rd_col = {4'd0, r[7:4]};
            end
            @(negedge clk);
            if (cmd_valid && cmd_ready) sent++;
            if (rd_req && !rd_busy) begin
                pending = 1'b1;
                raddr = int'(rd_row) * PANEL_WIDTH + int'(rd_col);
            end
            if (rd_ack) begin
                if (rd_data !== model[raddr] && rd_data !== new_px) begin
                    $display("mismatch rd_data at address %0d: got %h, expected %h or %h",
                             raddr, rd_data, model[raddr], new_px);
                    test_errs++;
                end
                pending = 1'b0;
            end
            if (cmd_done) pulses++;
            @(posedge clk);
            #1;
        end
        cmd_valid = 1'b0;
        rd_req = 1'b0;
        watch_done(WATCH_CYCLES, extra);
        if (pulses + extra != 1) begin
            $display("fill under reads gave %0d cmd_done pulses instead of one", pulses + extra);
            test_errs++;
        end
    endtask

    task automatic run_entry(input int num, input entry_t e);
        int pulses;
        test_errs = 0;
        case (e.kind)
            K_CMD, K_BAD: begin
                for (int i = 0; i < int'(e.nbytes); i++) send_byte(e.bytes[i]);
                if (e.kind == K_CMD) begin
                    wait_done(pulses);
                    if (pulses != 1) begin
                        $display("command gave %0d cmd_done pulses instead of one", pulses);
                        test_errs++;
                    end
                    update_model(e);
                end else begin
                    watch_done(WATCH_CYCLES, pulses);
                    if (pulses != 0) begin
                        $display("unknown opcode gave %0d cmd_done pulses instead of none",
                                 pulses);
                        test_errs++;
                    end
                    if (cmd_ready !== 1'b1) begin
                        $display("mismatch cmd_ready after unknown opcode: got %h, expected 1",
                                 cmd_ready);
                        test_errs++;
                    end
                end
            end
            K_READ: compare_read(e.row, e.col, e.exp_px);
            K_SWEEP: begin
                for (int r = 0; r < PANEL_HEIGHT; r++) begin
                    for (int c = 0; c < PANEL_WIDTH; c++) begin
                        compare_read(8'(r), 8'(c), model[r * PANEL_WIDTH + c]);
                    end
                end
            end
            default: begin
                fill_under_reads(e);
                update_model(e);
            end
        endcase
        report(num);
    endtask

    task automatic report(input int num);
        if (test_errs == 0) begin
            $display("test %0d ok", num);
        end else begin
            $display("test %0d FAILED with %0d errors", num, test_errs);
            failed++;
        end
        total_errs += test_errs;
    endtask

    initial begin
        seed = 32'hf6acbbac;
        cycles = 0;
        total_errs = 0;
        failed = 0;
        clk = 1'b0;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_data = 8'h00;
        rd_req = 1'b0;
        rd_row = 8'h00;
        rd_col = 8'h00;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        test_errs = 0;
        if (cmd_ready !== 1'b1) begin
            $display("mismatch cmd_ready after reset: got %h, expected 1", cmd_ready);
            test_errs++;
        end
        if (cmd_done !== 1'b0) begin
            $display("mismatch cmd_done after reset: got %h, expected 0", cmd_done);
            test_errs++;
        end
        if (rd_busy !== 1'b0) begin
            $display("mismatch rd_busy after reset: got %h, expected 0", rd_busy);
            test_errs++;
        end
        if (rd_ack !== 1'b0) begin
            $display("mismatch rd_ack after reset: got %h, expected 0", rd_ack);
            test_errs++;
        end
        report(0);
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_ENTRIES; i++) run_entry(i + 1, TESTS[i]);
        $display("summary: %0d tests run, %0d failing, %0d errors", NUM_ENTRIES + 1, failed,
                 total_errs);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/panel_pkg.sv
verilog/fb_bus_if.sv
verilog/cmd_stream_if.sv
verilog/fb_arbiter.sv
verilog/framebuffer_ram.sv
verilog/cmd_dispatch.sv
verilog/cmd_fill_panel.sv
verilog/cmd_set_pixel.sv
verilog/pixel_reader.sv
verilog/panel_ctrl_top.sv
bench/panel_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the panel controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module panel_ctrl_tb -Mdir obj_dir \
    && ./obj_dir/Vpanel_ctrl_tb | tee sim.log \
    && grep -q "^all tests passed$" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
